/* hw/adc_pkg.sv */
// multi-slope adc controller shared definitions
// spi frame, run-up config, result layout and the register map
package adc_pkg;

  // one completed spi frame, address byte first
  typedef struct packed {
    logic [7:0]  addr;
    logic [23:0] data;
  } spi_frame_t;

  // run-up settings driven from the register bank
  typedef struct packed {
    logic        enable;
    logic [15:0] phase_len;
    logic [23:0] phase_count;
  } adc_cfg_t;

  // one finished conversion
  typedef struct packed {
    logic [23:0] count_up;
    logic [23:0] count_down;
    logic [23:0] count_rundown;
  } adc_result_t;

  ////////////////////
  // register map, addr bit 7 set means read only
  localparam logic [7:0] REG_LED         = 8'd7;
  localparam logic [7:0] REG_CTRL        = 8'd8;
  localparam logic [7:0] REG_UP          = 8'd9;
  localparam logic [7:0] REG_DOWN        = 8'd10;
  localparam logic [7:0] REG_RUNDOWN     = 8'd11;
  localparam logic [7:0] REG_PHASE_LEN   = 8'd12;
  localparam logic [7:0] REG_PHASE_COUNT = 8'd13;
  localparam logic [7:0] REG_STATUS      = 8'd14;
  localparam logic [7:0] REG_SOFT_RESET  = 8'd15;

  ////////////////////
  // reset and soft reset values
  localparam logic [2:0]  LED_DEFAULT     = 3'd5;
  localparam logic [15:0] DEF_PHASE_LEN   = 16'd16;
  localparam logic [23:0] DEF_PHASE_COUNT = 24'd10;

endpackage

/* hw/spi_slave.sv */
`timescale 1ns/1ps
// spi slave, 32-bit frames msb first, pins sampled in the clk domain
module spi_slave (
  input  logic                clk,
  input  logic                reset,
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                mosi,
  output logic                miso,
  output logic [7:0]          rd_addr,
  output logic                rd_req,
  input  logic [23:0]         rd_data,
  output adc_pkg::spi_frame_t frame,
  output logic                frame_valid
);

  // two sync flops, third flop is history for edge detect
  logic [2:0]  sclk_s;
  logic [2:0]  cs_s;
  logic [1:0]  mosi_s;
  logic        sclk_rise;
  logic        sclk_fall;
  logic        cs_active;
  logic        frame_end;
  logic [31:0] shift_in;
  logic [23:0] shift_out;
  logic [5:0]  bit_cnt;
  logic        rd_load;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_s <= '0;
      cs_s   <= '1;
    end
    else
    begin
      sclk_s <= {sclk_s[1:0], sclk};
      cs_s   <= {cs_s[1:0], cs_n};
    end
  end

  // mosi gets the same latency as sclk
  always_ff @(posedge clk)
    mosi_s <= {mosi_s[0], mosi};

  assign sclk_rise = sclk_s[1] & ~sclk_s[2];
  assign sclk_fall = ~sclk_s[1] & sclk_s[2];
  assign cs_active = ~cs_s[1];
  // cs rise after exactly 32 bits
  assign frame_end = ~cs_active & ~cs_s[2] & (bit_cnt == 6'd32);

  ////////////////////
  // bit counter, read request, miso shifter
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt     <= '0;
      shift_out   <= '0;
      miso        <= 1'b0;
      rd_req      <= 1'b0;
      rd_load     <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      rd_req      <= 1'b0;
      rd_load     <= rd_req;
      frame_valid <= frame_end;
      if (!cs_active)
      begin
        // cs high at any level drops the frame
        bit_cnt   <= '0;
        shift_out <= '0;
        miso      <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
        begin
          // saturate at 33 so overlong frames are never reported
          if (bit_cnt <= 6'd32)
            bit_cnt <= bit_cnt + 6'd1;
          // address byte is complete on the 8th rise
          if (bit_cnt == 6'd7)
            rd_req <= 1'b1;
        end
        // reg bank answers one cycle after rd_req
        if (rd_load)
          shift_out <= rd_data;
        else if (sclk_fall)
        begin
          miso      <= shift_out[23];
          shift_out <= {shift_out[22:0], 1'b0};
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
      shift_in <= {shift_in[30:0], mosi_s[1]};
    if (cs_active && sclk_rise && bit_cnt == 6'd7)
      rd_addr <= {shift_in[6:0], mosi_s[1]};
    if (frame_end)
      frame <= shift_in;
  end

endmodule

/* hw/reg_bank.sv */
`timescale 1ns/1ps
// register bank behind the spi port
// led and run-up config registers, result and status reads, fifo pop
module reg_bank #(
  parameter int LEVEL_W = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  adc_pkg::spi_frame_t  frame,
  input  logic                 frame_valid,
  input  logic [7:0]           rd_addr,
  input  logic                 rd_req,
  output logic [23:0]          rd_data,
  output adc_pkg::adc_cfg_t    cfg,
  output logic [2:0]           led,
  input  adc_pkg::adc_result_t head,
  input  logic [LEVEL_W-1:0]   level,
  output logic                 pop
);

  localparam adc_pkg::adc_cfg_t CFG_RESET = '{
    enable:      1'b0,
    phase_len:   adc_pkg::DEF_PHASE_LEN,
    phase_count: adc_pkg::DEF_PHASE_COUNT
  };

  logic       wr_en;
  logic       fifo_has_data;
  logic [7:0] rd_sel;
  logic [7:0] pop_sel;

  // bit 7 set keeps the transfer from writing
  assign wr_en         = frame_valid & ~frame.addr[7];
  assign fifo_has_data = (level != '0);
  // reads ignore the read-only bit
  assign rd_sel        = {1'b0, rd_addr[6:0]};
  assign pop_sel       = {1'b0, frame.addr[6:0]};

  // any rundown access pops, read-only or not, but never an empty fifo
  assign pop = frame_valid && (pop_sel == adc_pkg::REG_RUNDOWN) && fifo_has_data;

  ////////////////////
  // writes
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      led <= adc_pkg::LED_DEFAULT;
      cfg <= CFG_RESET;
    end
    else if (wr_en)
    begin
      case (frame.addr)
        adc_pkg::REG_LED:         led             <= frame.data[2:0];
        adc_pkg::REG_CTRL:        cfg.enable      <= frame.data[0];
        adc_pkg::REG_PHASE_LEN:   cfg.phase_len   <= frame.data[15:0];
        adc_pkg::REG_PHASE_COUNT: cfg.phase_count <= frame.data;
        adc_pkg::REG_SOFT_RESET:
        begin
          led <= adc_pkg::LED_DEFAULT;
          cfg <= CFG_RESET;
        end
        // result and status registers are not writable
        default: ;
      endcase
    end
  end

  ////////////////////
  // read mux, captured when the address byte arrives
  // result fields read as zero while the fifo is empty
  always_ff @(posedge clk)
  begin
    if (rd_req)
    begin
      case (rd_sel)
        adc_pkg::REG_LED:         rd_data <= {21'd0, led};
        adc_pkg::REG_CTRL:        rd_data <= {23'd0, cfg.enable};
        adc_pkg::REG_UP:          rd_data <= fifo_has_data ? head.count_up : '0;
        adc_pkg::REG_DOWN:        rd_data <= fifo_has_data ? head.count_down : '0;
        adc_pkg::REG_RUNDOWN:     rd_data <= fifo_has_data ? head.count_rundown : '0;
        adc_pkg::REG_PHASE_LEN:   rd_data <= {8'd0, cfg.phase_len};
        adc_pkg::REG_PHASE_COUNT: rd_data <= cfg.phase_count;
        adc_pkg::REG_STATUS:      rd_data <= 24'(level);
        default:                  rd_data <= '0;
      endcase
    end
  end

endmodule

/* hw/result_fifo.sv */
`timescale 1ns/1ps
// result fifo with fall-through head
// returns one credit per real pop, interrupt low while not empty
module result_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            wr,
  input  adc_pkg::adc_result_t            wr_data,
  input  logic                            pop,
  output adc_pkg::adc_result_t            head,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] level,
  output logic                            credit_return,
  output logic                            int_n
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  adc_pkg::adc_result_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [LVL_W-1:0]     level_next;
  logic                 do_wr;
  logic                 do_pop;

  // wrap at depth, so depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_pop = pop && (level != '0);
  assign do_wr  = wr && (level != LVL_W'(FIFO_DEPTH));
  assign head   = mem[rd_ptr];

  always_comb
  begin
    case ({do_wr, do_pop})
      2'b10:   level_next = level + 1'b1;
      2'b01:   level_next = level - 1'b1;
      default: level_next = level;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      level         <= '0;
      credit_return <= 1'b0;
      int_n         <= 1'b1;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      level         <= level_next;
      credit_return <= do_pop;
      // follow next level so int_n drops with the write
      int_n         <= (level_next == '0);
    end
  end

endmodule

/* hw/integ_sequencer.sv */
`timescale 1ns/1ps
// multi-slope run-up and run-down sequencer
// steers the integrator input mux, counts phases and run-down cycles
module integ_sequencer #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  adc_pkg::adc_cfg_t    cfg,
  input  logic                 cmpr_out,
  input  logic                 credit_return,
  output logic [2:0]           mux,
  output adc_pkg::adc_result_t result,
  output logic                 result_valid
);

  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  // integrator input selects
  localparam logic [2:0] MUX_OFF    = 3'b000;
  localparam logic [2:0] MUX_LO_SEL = 3'b001;
  localparam logic [2:0] MUX_HI_SEL = 3'b010;

  typedef enum logic [1:0] {IDLE, RUNUP, RUNDOWN, DONE} state_t;

  state_t              state;
  logic [2:0]          cmpr_s;
  logic                cmpr;
  logic                cross_up;
  logic                cross_down;
  logic                cross_any;
  logic [15:0]         phase_cyc;
  logic [23:0]         phase_idx;
  logic                phase_end;
  logic                runup_end;
  logic                start;
  logic                consume;
  logic [CREDIT_W-1:0] credits;
  logic [23:0]         count_up;
  logic [23:0]         count_down;
  logic [23:0]         count_rundown;

  ////////////////////
  // comparator sync, bit 2 is history
  always_ff @(posedge clk)
  begin
    if (reset)
      cmpr_s <= '0;
    else
      cmpr_s <= {cmpr_s[1:0], cmpr_out};
  end

  assign cmpr       = cmpr_s[1];
  assign cross_up   = cmpr_s[1] & ~cmpr_s[2];
  assign cross_down = ~cmpr_s[1] & cmpr_s[2];
  // seen 3 cycles after the pin moves
  assign cross_any  = cross_up | cross_down;

  assign phase_end = (phase_cyc == cfg.phase_len - 16'd1);
  assign runup_end = phase_end && (phase_idx == cfg.phase_count - 24'd1);
  // only start while holding a credit
  assign start     = (state == IDLE) && cfg.enable && (credits != '0);
  assign consume   = (state == RUNDOWN) && cross_any;

  ////////////////////
  // credits, one spent per result and one back per fifo pop
  always_ff @(posedge clk)
  begin
    if (reset)
      credits <= CREDIT_W'(FIFO_DEPTH);
    else
    begin
      case ({credit_return, consume})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////
  // state machine
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state        <= IDLE;
      mux          <= MUX_OFF;
      result_valid <= 1'b0;
      phase_cyc    <= '0;
      phase_idx    <= '0;
    end
    else
    begin
      result_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          mux <= MUX_OFF;
          if (start)
          begin
            // first phase always integrates on the lo select
            state     <= RUNUP;
            mux       <= MUX_LO_SEL;
            phase_cyc <= '0;
            phase_idx <= '0;
          end
        end
        RUNUP:
        begin
          if (phase_end)
          begin
            // comparator picks the next slope
            phase_cyc <= '0;
            phase_idx <= phase_idx + 24'd1;
            mux       <= cmpr ? MUX_HI_SEL : MUX_LO_SEL;
            if (runup_end)
              state <= RUNDOWN;
          end
          else
            phase_cyc <= phase_cyc + 16'd1;
        end
        RUNDOWN:
        begin
          // last run-up slope holds until the crossing
          if (cross_any)
          begin
            mux          <= MUX_OFF;
            result_valid <= 1'b1;
            state        <= DONE;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // conversion counters, held through DONE for the fifo write
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      count_up      <= '0;
      count_down    <= '0;
      count_rundown <= '0;
    end
    else if (state == RUNUP && phase_end)
    begin
      if (cmpr)
        count_up <= count_up + 24'd1;
      else
        count_down <= count_down + 24'd1;
    end
    // crossing cycle is counted too
    else if (state == RUNDOWN)
      count_rundown <= count_rundown + 24'd1;
  end

  assign result = '{
    count_up:      count_up,
    count_down:    count_down,
    count_rundown: count_rundown
  };

endmodule

/* hw/adc_top.sv */
`timescale 1ns/1ps
// multi-slope adc controller top level
// spi register access, credit-based result fifo, integrator sequencer
module adc_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_sclk,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  input  logic       cmpr_out,
  output logic       spi_miso,
  output logic       int_n,
  output logic [2:0] led,
  output logic [2:0] mux
);

  // spi to register bank
  adc_pkg::spi_frame_t             frame;
  logic                            frame_valid;
  logic [7:0]                      rd_addr;
  logic                            rd_req;
  logic [23:0]                     rd_data;
  // register bank to sequencer and fifo
  adc_pkg::adc_cfg_t               cfg;
  adc_pkg::adc_result_t            head;
  logic [$clog2(FIFO_DEPTH+1)-1:0] level;
  logic                            pop;
  // sequencer and fifo credit loop
  adc_pkg::adc_result_t            result;
  logic                            result_valid;
  logic                            credit_return;

  spi_slave spi_slave_i (
    .clk         (clk),
    .reset       (reset),
    .sclk        (spi_sclk),
    .cs_n        (spi_cs_n),
    .mosi        (spi_mosi),
    .miso        (spi_miso),
    .rd_addr     (rd_addr),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  reg_bank #(
    .LEVEL_W ($clog2(FIFO_DEPTH + 1))
  ) reg_bank_i (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .cfg         (cfg),
    .led         (led),
    .head        (head),
    .level       (level),
    .pop         (pop)
  );

  result_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) result_fifo_i (
    .clk           (clk),
    .reset         (reset),
    .wr            (result_valid),
    .wr_data       (result),
    .pop           (pop),
    .head          (head),
    .level         (level),
    .credit_return (credit_return),
    .int_n         (int_n)
  );

  integ_sequencer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) integ_sequencer_i (
    .clk           (clk),
    .reset         (reset),
    .cfg           (cfg),
    .cmpr_out      (cmpr_out),
    .credit_return (credit_return),
    .mux           (mux),
    .result        (result),
    .result_valid  (result_valid)
  );

endmodule

/* tests/adc_tb.sv */
`timescale 1ns/1ps
// multi-slope adc controller testbench
// spi host, comparator driver, directed register and conversion tests
module adc_tb;

  localparam int         CYCLE_LIMIT = 20000;
  localparam logic [7:0] RD_ONLY     = 8'h80;

  logic       clk = 1'b0;
  logic       reset;
  logic       spi_sclk;
  logic       spi_cs_n;
  logic       spi_mosi;
  logic       cmpr_out;
  logic       spi_miso;
  logic       int_n;
  logic [2:0] led;
  logic [2:0] mux;

  // negedge cycle count, stable whenever a posedge process reads it
  int          cycle = 0;
  logic [2:0]  prev_mux = 3'b000;
  // cycle value of each posedge where mux left 000
  int          starts[$];
  adc_pkg::adc_result_t expected[$];
  logic [31:0] rng;

  adc_top #(
    .FIFO_DEPTH (4)
  ) adc_top_i (
    .clk      (clk),
    .reset    (reset),
    .spi_sclk (spi_sclk),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .cmpr_out (cmpr_out),
    .spi_miso (spi_miso),
    .int_n    (int_n),
    .led      (led),
    .mux      (mux)
  );

  always #50 clk = ~clk;

  // watchdog
  always @(negedge clk)
  begin
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycle);
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
    end
    else
      cycle <= cycle + 1;
  end

  // conversion start monitor
  always @(negedge clk)
  begin
    prev_mux <= mux;
    if (!reset && prev_mux == 3'b000 && mux != 3'b000)
      starts.push_back(cycle);
  end

  ////////////////////
  // check helpers
  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_equal(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("error: %s", what);
      end_with_failure();
    end
  endtask

  // 32-bit lcg, numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////
  // spi host, mode 0, 4 clk cycles per sclk half period
  task automatic spi_xfer(input logic [7:0] addr, input logic [23:0] wdata,
                          output logic [23:0] rdata);
    logic [31:0] word;
    word  = {addr, wdata};
    rdata = '0;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    spi_mosi <= word[31];
    repeat (3) @(posedge clk);
    for (int i = 31; i >= 0; i--)
    begin
      // miso is sampled just before the rising edge
      if (i < 24)
      begin
        @(negedge clk);
        rdata[i] = spi_miso;
      end
      @(posedge clk);
      spi_sclk <= 1'b1;
      repeat (4) @(posedge clk);
      spi_sclk <= 1'b0;
      if (i > 0)
        spi_mosi <= word[i-1];
      repeat (3) @(posedge clk);
    end
    @(posedge clk);
    spi_cs_n <= 1'b1;
    spi_mosi <= 1'b0;
    // frame_valid and the register write land a few cycles after cs rises
    repeat (6) @(posedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset    <= 1'b1;
    cmpr_out <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    starts.delete();
    expected.delete();
  endtask

  task automatic configure(input int len, input int count);
    logic [23:0] rd;
    spi_xfer(adc_pkg::REG_PHASE_LEN, 24'(len), rd);
    spi_xfer(adc_pkg::REG_PHASE_COUNT, 24'(count), rd);
    spi_xfer(adc_pkg::REG_CTRL, 24'd1, rd);
  endtask

  // called from posedge context only
  task automatic wait_edge(input int t);
    check_true(t > cycle, "comparator driver fell behind the run-up");
    while (cycle < t)
      @(posedge clk);
  endtask

  ////////////////////
  // comparator driver for one conversion
  // levels change mid-phase, run-down crossing comes delay cycles after run-up
  task automatic run_conversion(input int len, input int n, input int delay,
                                input logic [23:0] levels);
    int                   s;
    int                   ups;
    logic [2:0]           exp_mux;
    adc_pkg::adc_result_t res;
    ups = 0;
    @(posedge clk);
    while (starts.size() == 0)
      @(posedge clk);
    s = starts.pop_front();
    for (int k = 0; k < n; k++)
    begin
      wait_edge(s + k * len + len / 2);
      // first phase on 001, later ones follow the previous sample
      if (k == 0)
        exp_mux = 3'b001;
      else
        exp_mux = levels[k-1] ? 3'b010 : 3'b001;
      check_equal("mux", {21'd0, mux}, {21'd0, exp_mux});
      cmpr_out <= levels[k];
      if (levels[k])
        ups++;
    end
    wait_edge(s + n * len + delay);
    cmpr_out <= ~levels[n-1];
    // crossing closes the run-down and drops mux to 000
    @(negedge clk);
    while (mux != 3'b000)
      @(negedge clk);
    res.count_up      = 24'(ups);
    res.count_down    = 24'(n - ups);
    res.count_rundown = 24'(delay + 3);
    expected.push_back(res);
  endtask

  // full result read, rundown access pops the fifo
  task automatic read_result();
    adc_pkg::adc_result_t exp;
    logic [23:0]          up;
    logic [23:0]          down;
    logic [23:0]          rundown;
    check_true(expected.size() != 0, "a result was read that no conversion produced");
    exp = expected.pop_front();
    spi_xfer(RD_ONLY | adc_pkg::REG_UP, 24'd0, up);
    spi_xfer(RD_ONLY | adc_pkg::REG_DOWN, 24'd0, down);
    spi_xfer(RD_ONLY | adc_pkg::REG_RUNDOWN, 24'd0, rundown);
    check_equal("count_up", up, exp.count_up);
    check_equal("count_down", down, exp.count_down);
    check_equal("count_rundown", rundown, exp.count_rundown);
  endtask

  ////////////////////
  // tests
  task automatic test_registers();
    logic [23:0] rd;
    @(negedge clk);
    check_equal("led", {21'd0, led}, 24'h5);
    check_equal("mux", {21'd0, mux}, 24'h0);
    check_true(int_n === 1'b1, "int_n is not high after reset");
    spi_xfer(RD_ONLY | adc_pkg::REG_LED, 24'd0, rd);
    check_equal("REG_LED", rd, 24'h5);
    spi_xfer(adc_pkg::REG_LED, 24'h3, rd);
    spi_xfer(RD_ONLY | adc_pkg::REG_LED, 24'd0, rd);
    check_equal("REG_LED", rd, 24'h3);
    @(negedge clk);
    check_equal("led", {21'd0, led}, 24'h3);
    // read-only access returns the value and must not write it
    spi_xfer(RD_ONLY | adc_pkg::REG_LED, 24'h6, rd);
    check_equal("REG_LED", rd, 24'h3);
    spi_xfer(RD_ONLY | adc_pkg::REG_LED, 24'd0, rd);
    check_equal("REG_LED", rd, 24'h3);
    @(negedge clk);
    check_equal("led", {21'd0, led}, 24'h3);
  endtask

  task automatic test_soft_reset();
    logic [23:0] rd;
    spi_xfer(adc_pkg::REG_PHASE_LEN, 24'h55, rd);
    spi_xfer(adc_pkg::REG_LED, 24'h2, rd);
    spi_xfer(RD_ONLY | adc_pkg::REG_PHASE_LEN, 24'd0, rd);
    check_equal("REG_PHASE_LEN", rd, 24'h55);
    spi_xfer(adc_pkg::REG_SOFT_RESET, 24'd0, rd);
    spi_xfer(RD_ONLY | adc_pkg::REG_PHASE_LEN, 24'd0, rd);
    check_equal("REG_PHASE_LEN", rd, 24'd16);
    spi_xfer(RD_ONLY | adc_pkg::REG_LED, 24'd0, rd);
    check_equal("REG_LED", rd, 24'h5);
    @(negedge clk);
    check_equal("led", {21'd0, led}, 24'h5);
  endtask

  task automatic test_cmpr_high();
    apply_reset();
    configure(8, 6);
    run_conversion(8, 6, 7, 24'hffffff);
    // fifo write and int_n follow result_valid by one cycle
    while (int_n !== 1'b0)
      @(negedge clk);
    read_result();
  endtask

  task automatic test_random();
    logic [23:0] levels;
    apply_reset();
    configure(10, 8);
    for (int c = 0; c < 3; c++)
    begin
      levels = '0;
      for (int k = 0; k < 8; k++)
      begin
        rng       = lcg_next(rng);
        levels[k] = rng[31];
      end
      run_conversion(10, 8, 2 + 4 * c, levels);
    end
    // oldest result first
    for (int c = 0; c < 3; c++)
      read_result();
  endtask

  task automatic test_backpressure();
    logic [23:0] rd;
    apply_reset();
    configure(8, 6);
    for (int c = 0; c < 4; c++)
      run_conversion(8, 6, 1 + c, 24'h00002d);
    // fifo full and no credits left, sequencer has to sit in IDLE
    repeat (6 * 8 + 8)
    begin
      @(negedge clk);
      check_equal("mux", {21'd0, mux}, 24'h0);
    end
    check_true(starts.size() == 0, "a conversion started without a credit");
    check_true(int_n === 1'b0, "int_n is high with a full fifo");
    spi_xfer(RD_ONLY | adc_pkg::REG_STATUS, 24'd0, rd);
    check_equal("REG_STATUS", rd, 24'd4);
    // one pop hands back one credit
    read_result();
    run_conversion(8, 6, 9, 24'h000015);
    repeat (4) read_result();
    @(negedge clk);
    check_true(int_n === 1'b1, "int_n stayed low after the fifo was drained");
    spi_xfer(RD_ONLY | adc_pkg::REG_STATUS, 24'd0, rd);
    check_equal("REG_STATUS", rd, 24'd0);
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    reset    <= 1'b1;
    spi_sclk <= 1'b0;
    spi_cs_n <= 1'b1;
    spi_mosi <= 1'b0;
    cmpr_out <= 1'b0;
    rng = 32'hd771_6af5;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_registers();
    test_soft_reset();
    test_cmpr_high();
    test_random();
    test_backpressure();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* flist.f */
hw/adc_pkg.sv
hw/spi_slave.sv
hw/reg_bank.sv
hw/result_fifo.sv
hw/integ_sequencer.sv
hw/adc_top.sv
tests/adc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the adc controller testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f flist.f --top-module adc_tb -o adc_tb_sim &&
./obj_dir/adc_tb_sim || exit 1
